// File: list.f
mem_island_cfg_pkg.sv
mem_island_types_pkg.sv
mem_island_ifs.sv
addr_decode.sv
bank_arbiter.sv
bank_array.sv
rsp_merge.sv
mem_island_top.sv
tb_clk_gen.sv
tb_mem_island.sv

// File: Bender.yml
package:
  name: mem_island

sources:
  - mem_island_cfg_pkg.sv
  - mem_island_types_pkg.sv
  - mem_island_ifs.sv
  - addr_decode.sv
  - bank_arbiter.sv
  - bank_array.sv
  - rsp_merge.sv
  - mem_island_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem_island.sv

// File: tb_mem_island.sv
// Testbench for the memory island with random traffic, reference model and response checks
`timescale 1ns/1ns

module tb_mem_island;

    // Fill pass writes every narrow word once, then random traffic on both ports
    localparam int unsigned FILL_WORDS = 256;
    localparam int unsigned N_RAND     = 300;
    localparam int unsigned N_TOTAL    = FILL_WORDS + 2 * N_RAND;
    localparam int unsigned TIMEOUT    = N_TOTAL * 4 + 50;

    // Expected response, due cycle and read data
    typedef struct packed {
        int unsigned due;
        logic        rd;
        logic [63:0] data;
    } rsp_t;

    logic                         clk;
    logic                         arst_n;
    logic                         narrow_req;
    logic                         narrow_we;
    mem_island_types_pkg::addr_t  narrow_addr;
    mem_island_types_pkg::ndata_t narrow_wdata;
    mem_island_types_pkg::nbe_t   narrow_be;
    logic                         narrow_gnt;
    logic                         narrow_rvalid;
    mem_island_types_pkg::ndata_t narrow_rdata;
    logic                         wide_req;
    logic                         wide_we;
    mem_island_types_pkg::addr_t  wide_addr;
    mem_island_types_pkg::wdata_t wide_wdata;
    mem_island_types_pkg::wbe_t   wide_be;
    logic                         wide_gnt;
    logic                         wide_rvalid;
    mem_island_types_pkg::wdata_t wide_rdata;

    // Model state
    logic [31:0]                  lcg_state = 32'h0dd0_7056;
    mem_island_types_pkg::ndata_t model_mem [256];
    mem_island_types_pkg::prio_e  prio_model;
    rsp_t                         narrow_pend [$];
    rsp_t                         wide_pend [$];
    logic                         narrow_acc;
    logic                         wide_acc;
    int unsigned                  cyc;
    int unsigned                  tmo_cnt;
    int unsigned                  narrow_sent;
    int unsigned                  wide_sent;
    int unsigned                  grant_errs;
    int unsigned                  timing_errs;
    int unsigned                  data_errs;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    mem_island_top dut0 (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .narrow_req_i   (narrow_req),
        .narrow_we_i    (narrow_we),
        .narrow_addr_i  (narrow_addr),
        .narrow_wdata_i (narrow_wdata),
        .narrow_be_i    (narrow_be),
        .narrow_gnt_o   (narrow_gnt),
        .narrow_rvalid_o(narrow_rvalid),
        .narrow_rdata_o (narrow_rdata),
        .wide_req_i     (wide_req),
        .wide_we_i      (wide_we),
        .wide_addr_i    (wide_addr),
        .wide_wdata_i   (wide_wdata),
        .wide_be_i      (wide_be),
        .wide_gnt_o     (wide_gnt),
        .wide_rvalid_o  (wide_rvalid),
        .wide_rdata_o   (wide_rdata)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Byte strobed update of one narrow word
    function automatic mem_island_types_pkg::ndata_t apply_strobe(
        input mem_island_types_pkg::ndata_t old_word,
        input mem_island_types_pkg::ndata_t new_word,
        input mem_island_types_pkg::nbe_t   be
    );
        mem_island_types_pkg::ndata_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // Response of one port, pulse due RSP_LAT edges after acceptance
    task automatic check_rsp(input int unsigned port, input logic rvalid, input logic [63:0] rdata);
        rsp_t  head;
        logic  have;
        string name;
        name = (port == 0) ? "narrow" : "wide";
        have = (port == 0) ? (narrow_pend.size() != 0) : (wide_pend.size() != 0);
        if (have) begin
            head = (port == 0) ? narrow_pend[0] : wide_pend[0];
        end
        if (have && head.due == cyc) begin
            if (port == 0) begin
                void'(narrow_pend.pop_front());
            end else begin
                void'(wide_pend.pop_front());
            end
            if (rvalid !== 1'b1) begin
                timing_errs++;
                $display("%s port: no rvalid pulse %0d cycles after acceptance at cycle %0d",
                         name, mem_island_cfg_pkg::RSP_LAT,
                         head.due - mem_island_cfg_pkg::RSP_LAT);
            end else if (head.rd && rdata !== head.data) begin
                data_errs++;
                $display("Fail %s_read: expected %h actual %h", name, head.data, rdata);
            end
        end else if (rvalid !== 1'b0) begin
            timing_errs++;
            $display("%s port: rvalid pulse without matching accepted request at cycle %0d",
                     name, cyc);
        end
    endtask

    // Conflict when the narrow bank sits in the wide pair, address bit 3 on both
    task automatic check_grants();
        logic conflict;
        logic exp_n;
        logic exp_w;
        conflict = narrow_req && wide_req && (narrow_addr[3] == wide_addr[3]);
        exp_n = narrow_req && (!conflict || prio_model == mem_island_types_pkg::PRIO_NARROW);
        exp_w = wide_req && (!conflict || prio_model == mem_island_types_pkg::PRIO_WIDE);
        if (narrow_gnt !== exp_n) begin
            grant_errs++;
            $display("Fail narrow_grant: expected %b actual %b", exp_n, narrow_gnt);
        end
        if (wide_gnt !== exp_w) begin
            grant_errs++;
            $display("Fail wide_grant: expected %b actual %b", exp_w, wide_gnt);
        end
        // Loser of a conflict wins the next one
        if (conflict) begin
            prio_model = (prio_model == mem_island_types_pkg::PRIO_NARROW) ?
                         mem_island_types_pkg::PRIO_WIDE : mem_island_types_pkg::PRIO_NARROW;
        end
    endtask

    // Model update at the acceptance edge, narrow first
    task automatic record_accepts();
        rsp_t       entry;
        logic [7:0] idx;
        narrow_acc = narrow_req && narrow_gnt === 1'b1;
        wide_acc   = wide_req && wide_gnt === 1'b1;
        entry.due  = cyc + mem_island_cfg_pkg::RSP_LAT;
        if (narrow_acc) begin
            idx        = narrow_addr[9:2];
            entry.rd   = !narrow_we;
            entry.data = {32'h0, model_mem[idx]};
            narrow_pend.push_back(entry);
            if (narrow_we) begin
                model_mem[idx] = apply_strobe(model_mem[idx], narrow_wdata, narrow_be);
            end
        end
        if (wide_acc) begin
            // Even word of the pair holds the low half
            idx        = {wide_addr[9:3], 1'b0};
            entry.rd   = !wide_we;
            entry.data = {model_mem[idx + 1], model_mem[idx]};
            wide_pend.push_back(entry);
            if (wide_we) begin
                model_mem[idx]     = apply_strobe(model_mem[idx], wide_wdata[31:0], wide_be[3:0]);
                model_mem[idx + 1] = apply_strobe(model_mem[idx + 1], wide_wdata[63:32],
                                                  wide_be[7:4]);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus, a request is held until granted
    // ------------------------------------------------------------------------
    task automatic drive_next();
        logic [31:0] r;
        logic [7:0]  fi;
        if (!narrow_req || narrow_acc) begin
            r = lcg_next();
            if (narrow_sent < FILL_WORDS) begin
                // Fill word built from the whole word address
                fi = narrow_sent[7:0];
                narrow_req   <= 1'b1;
                narrow_we    <= 1'b1;
                narrow_addr  <= {2'b00, fi, 2'b00};
                narrow_wdata <= {8'hc0, fi, ~fi, fi ^ 8'h5a};
                narrow_be    <= 4'hf;
                narrow_sent++;
            end else if (narrow_sent < FILL_WORDS + N_RAND && r[31:30] != 2'b00) begin
                narrow_req   <= 1'b1;
                narrow_we    <= r[29];
                narrow_addr  <= {2'b00, r[25:16]};
                narrow_be    <= r[15:12];
                narrow_wdata <= lcg_next();
                narrow_sent++;
            end else begin
                narrow_req <= 1'b0;
            end
        end
        if (!wide_req || wide_acc) begin
            r = lcg_next();
            // Wide traffic starts once the fill is issued
            if (narrow_sent >= FILL_WORDS && wide_sent < N_RAND && r[31:30] != 2'b00) begin
                wide_req   <= 1'b1;
                wide_we    <= r[29];
                wide_addr  <= {2'b00, r[25:19], 3'b000};
                wide_be    <= r[11:4];
                wide_wdata <= {lcg_next(), lcg_next()};
                wide_sent++;
            end else begin
                wide_req <= 1'b0;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin : main
        narrow_req   = 1'b0;
        narrow_we    = 1'b0;
        narrow_addr  = '0;
        narrow_wdata = '0;
        narrow_be    = '0;
        wide_req     = 1'b0;
        wide_we      = 1'b0;
        wide_addr    = '0;
        wide_wdata   = '0;
        wide_be      = '0;
        prio_model   = mem_island_types_pkg::PRIO_NARROW;
        narrow_acc   = 1'b0;
        wide_acc     = 1'b0;
        cyc          = 0;
        narrow_sent  = 0;
        wide_sent    = 0;
        grant_errs   = 0;
        timing_errs  = 0;
        data_errs    = 0;
        wait (arst_n === 1'b1);
        while (narrow_sent < FILL_WORDS + N_RAND || wide_sent < N_RAND || narrow_req ||
               wide_req || narrow_pend.size() != 0 || wide_pend.size() != 0) begin
            @(posedge clk);
            cyc++;
            check_rsp(0, narrow_rvalid, {32'h0, narrow_rdata});
            check_rsp(1, wide_rvalid, wide_rdata);
            check_grants();
            record_accepts();
            drive_next();
        end
        $display("errors: grant %0d, timing %0d, data %0d", grant_errs, timing_errs, data_errs);
        if (grant_errs + timing_errs + data_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Run limit from the transaction count
    initial begin : watchdog
        tmo_cnt = 0;
        while (tmo_cnt <= TIMEOUT) begin
            @(posedge clk);
            tmo_cnt++;
        end
        $display("timeout: traffic did not drain within %0d cycles", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int unsigned PERIOD = 20;

    // Free running clock, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset low for two full cycles, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        #(2 * PERIOD) arst_n_o = 1'b1;
    end

endmodule

// File: mem_island_top.sv
// Memory island top level with narrow and wide ports over a shared bank array
`timescale 1ns/1ns

module mem_island_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Narrow port
    input  logic                         narrow_req_i,
    input  logic                         narrow_we_i,
    input  mem_island_types_pkg::addr_t  narrow_addr_i,
    input  mem_island_types_pkg::ndata_t narrow_wdata_i,
    input  mem_island_types_pkg::nbe_t   narrow_be_i,
    output logic                         narrow_gnt_o,
    output logic                         narrow_rvalid_o,
    output mem_island_types_pkg::ndata_t narrow_rdata_o,
    // Wide port
    input  logic                         wide_req_i,
    input  logic                         wide_we_i,
    input  mem_island_types_pkg::addr_t  wide_addr_i,
    input  mem_island_types_pkg::wdata_t wide_wdata_i,
    input  mem_island_types_pkg::wbe_t   wide_be_i,
    output logic                         wide_gnt_o,
    output logic                         wide_rvalid_o,
    output mem_island_types_pkg::wdata_t wide_rdata_o
);

    dec_req_if  dec_if ();
    bank_req_if bank_if ();
    rsp_tag_if  tag_if ();

    // Registered read data of every bank
    mem_island_types_pkg::ndata_t bank_rdata [mem_island_cfg_pkg::NUM_BANKS];

    // ------------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------------
    addr_decode u_addr_decode (
        .narrow_req_i  (narrow_req_i),
        .narrow_we_i   (narrow_we_i),
        .narrow_addr_i (narrow_addr_i),
        .narrow_wdata_i(narrow_wdata_i),
        .narrow_be_i   (narrow_be_i),
        .wide_req_i    (wide_req_i),
        .wide_we_i     (wide_we_i),
        .wide_addr_i   (wide_addr_i),
        .wide_wdata_i  (wide_wdata_i),
        .wide_be_i     (wide_be_i),
        .dec_o         (dec_if.src)
    );

    bank_arbiter u_bank_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_i       (dec_if.dst),
        .narrow_gnt_o(narrow_gnt_o),
        .wide_gnt_o  (wide_gnt_o),
        .bank_o      (bank_if.arb),
        .tag_o       (tag_if.arb)
    );

    bank_array u_bank_array (
        .clk_i  (clk_i),
        .bank_i (bank_if.mem),
        .rdata_o(bank_rdata)
    );

    rsp_merge u_rsp_merge (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .tag_i          (tag_if.merge),
        .rdata_i        (bank_rdata),
        .narrow_rvalid_o(narrow_rvalid_o),
        .narrow_rdata_o (narrow_rdata_o),
        .wide_rvalid_o  (wide_rvalid_o),
        .wide_rdata_o   (wide_rdata_o)
    );

endmodule

// File: rsp_merge.sv
// Response merge stage aligning tags with bank data and building port responses
`timescale 1ns/1ns

module rsp_merge (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    rsp_tag_if.merge                     tag_i,
    input  mem_island_types_pkg::ndata_t rdata_i [mem_island_cfg_pkg::NUM_BANKS],
    output logic                         narrow_rvalid_o,
    output mem_island_types_pkg::ndata_t narrow_rdata_o,
    output logic                         wide_rvalid_o,
    output mem_island_types_pkg::wdata_t wide_rdata_o
);

    // Tags one stage late, in step with the bank read registers
    logic                            narrow_acc_q;
    logic                            wide_acc_q;
    mem_island_types_pkg::bank_idx_t narrow_bank_q;
    mem_island_types_pkg::pair_idx_t wide_pair_q;
    // Even bank of the tagged pair
    mem_island_types_pkg::bank_idx_t wide_base;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            narrow_acc_q    <= 1'b0;
            wide_acc_q      <= 1'b0;
            narrow_rvalid_o <= 1'b0;
            wide_rvalid_o   <= 1'b0;
        end else begin
            narrow_acc_q    <= tag_i.narrow_acc;
            wide_acc_q      <= tag_i.wide_acc;
            narrow_rvalid_o <= narrow_acc_q;
            wide_rvalid_o   <= wide_acc_q;
        end
    end

    assign wide_base = mem_island_types_pkg::bank_idx_t'(wide_pair_q *
                                                         mem_island_cfg_pkg::BANKS_PER_WIDE);

    always_ff @(posedge clk_i) begin
        narrow_bank_q <= tag_i.narrow_bank;
        wide_pair_q   <= tag_i.wide_pair;
        if (narrow_acc_q) begin
            narrow_rdata_o <= rdata_i[narrow_bank_q];
        end
        // Odd bank fills the upper half
        if (wide_acc_q) begin
            wide_rdata_o <= {rdata_i[wide_base + 1'b1], rdata_i[wide_base]};
        end
    end

endmodule

// File: bank_array.sv
// Four byte-strobed single-port narrow banks with registered read data
`timescale 1ns/1ns

module bank_array (
    input  logic                         clk_i,
    bank_req_if.mem                      bank_i,
    output mem_island_types_pkg::ndata_t rdata_o [mem_island_cfg_pkg::NUM_BANKS]
);

    for (genvar b = 0; b < mem_island_cfg_pkg::NUM_BANKS; b++) begin : gen_bank
        // Storage of one bank
        mem_island_types_pkg::ndata_t mem_q [mem_island_cfg_pkg::WORDS_PER_BANK];
        mem_island_types_pkg::ndata_t rdata_q;

        always_ff @(posedge clk_i) begin
            if (bank_i.en[b]) begin
                // Old contents, writes answer without data
                rdata_q <= mem_q[bank_i.row[b]];
                if (bank_i.we[b]) begin
                    for (int i = 0; i < $bits(mem_island_types_pkg::nbe_t); i++) begin
                        // Only strobed bytes change
                        if (bank_i.be[b][i]) begin
                            mem_q[bank_i.row[b]][i*8 +: 8] <= bank_i.wdata[b][i*8 +: 8];
                        end
                    end
                end
            end
        end

        assign rdata_o[b] = rdata_q;
    end

endmodule

// File: bank_arbiter.sv
// Bank arbitration stage with conflict detection, grant logic and lane steering
`timescale 1ns/1ns

module bank_arbiter (
    input  logic   clk_i,
    input  logic   arst_n_i,
    dec_req_if.dst dec_i,
    output logic   narrow_gnt_o,
    output logic   wide_gnt_o,
    bank_req_if.arb bank_o,
    rsp_tag_if.arb tag_o
);

    mem_island_types_pkg::prio_e prio_q;
    logic conflict;
    // Banks claimed by each port this cycle
    logic [mem_island_cfg_pkg::NUM_BANKS-1:0] narrow_lane;
    logic [mem_island_cfg_pkg::NUM_BANKS-1:0] wide_lane;

    // ------------------------------------------------------------------------
    // Conflict detection and grants
    // ------------------------------------------------------------------------
    // Narrow bank inside the wide pair
    assign conflict = dec_i.narrow_valid && dec_i.wide_valid &&
        (mem_island_types_pkg::pair_idx_t'(dec_i.narrow_bank /
                                           mem_island_cfg_pkg::BANKS_PER_WIDE) == dec_i.wide_pair);

    assign narrow_gnt_o = dec_i.narrow_valid &&
        (!conflict || prio_q == mem_island_types_pkg::PRIO_NARROW);
    assign wide_gnt_o   = dec_i.wide_valid &&
        (!conflict || prio_q == mem_island_types_pkg::PRIO_WIDE);

    // Winner of a conflict hands priority to the loser
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q <= mem_island_types_pkg::PRIO_NARROW;
        end else if (conflict) begin
            prio_q <= (prio_q == mem_island_types_pkg::PRIO_NARROW) ?
                      mem_island_types_pkg::PRIO_WIDE : mem_island_types_pkg::PRIO_NARROW;
        end
    end

    // ------------------------------------------------------------------------
    // Lane steering
    // ------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < mem_island_cfg_pkg::NUM_BANKS; b++) begin
            narrow_lane[b] = narrow_gnt_o &&
                (dec_i.narrow_bank == mem_island_types_pkg::bank_idx_t'(b));
            wide_lane[b]   = wide_gnt_o && (dec_i.wide_pair ==
                mem_island_types_pkg::pair_idx_t'(b / mem_island_cfg_pkg::BANKS_PER_WIDE));
        end
    end

    always_comb begin
        bank_o.en    = '0;
        bank_o.we    = '0;
        bank_o.row   = '0;
        bank_o.wdata = '0;
        bank_o.be    = '0;
        for (int b = 0; b < mem_island_cfg_pkg::NUM_BANKS; b++) begin
            if (narrow_lane[b]) begin
                bank_o.en[b]    = 1'b1;
                bank_o.we[b]    = dec_i.narrow_we;
                bank_o.row[b]   = dec_i.narrow_row;
                bank_o.wdata[b] = dec_i.narrow_wdata;
                bank_o.be[b]    = dec_i.narrow_be;
            end else if (wide_lane[b]) begin
                // Even bank takes the low half, odd bank the high half
                bank_o.en[b]    = 1'b1;
                bank_o.we[b]    = dec_i.wide_we;
                bank_o.row[b]   = dec_i.wide_row;
                bank_o.wdata[b] = dec_i.wide_wdata[(b % mem_island_cfg_pkg::BANKS_PER_WIDE) *
                                  mem_island_cfg_pkg::NARROW_DW +: mem_island_cfg_pkg::NARROW_DW];
                bank_o.be[b]    = dec_i.wide_be[(b % mem_island_cfg_pkg::BANKS_PER_WIDE) *
                                  $bits(mem_island_types_pkg::nbe_t) +:
                                  $bits(mem_island_types_pkg::nbe_t)];
            end
        end
    end

    // Tags of the accesses issued this cycle
    assign tag_o.narrow_acc  = narrow_gnt_o;
    assign tag_o.narrow_bank = dec_i.narrow_bank;
    assign tag_o.wide_acc    = wide_gnt_o;
    assign tag_o.wide_pair   = dec_i.wide_pair;

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------
    // A bank serves one port per cycle
    a_lane_exclusive : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (narrow_lane & wide_lane) == '0);

    // Held loser of a conflict is served in the following cycle
    a_narrow_no_starve : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (conflict && !narrow_gnt_o) ##1 dec_i.narrow_valid |-> narrow_gnt_o);
    a_wide_no_starve : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (conflict && !wide_gnt_o) ##1 dec_i.wide_valid |-> wide_gnt_o);

endmodule

// File: addr_decode.sv
// Address decode stage splitting port addresses into bank, pair and row fields
`timescale 1ns/1ns

module addr_decode (
    input  logic                         narrow_req_i,
    input  logic                         narrow_we_i,
    input  mem_island_types_pkg::addr_t  narrow_addr_i,
    input  mem_island_types_pkg::ndata_t narrow_wdata_i,
    input  mem_island_types_pkg::nbe_t   narrow_be_i,
    input  logic                         wide_req_i,
    input  logic                         wide_we_i,
    input  mem_island_types_pkg::addr_t  wide_addr_i,
    input  mem_island_types_pkg::wdata_t wide_wdata_i,
    input  mem_island_types_pkg::wbe_t   wide_be_i,
    dec_req_if.src                       dec_o
);

    // Narrow side
    // Bank select right below the row field, byte offset ignored
    assign dec_o.narrow_valid = narrow_req_i;
    assign dec_o.narrow_we    = narrow_we_i;
    assign dec_o.narrow_bank  = narrow_addr_i[mem_island_cfg_pkg::ROW_LSB-1 -:
                                              $bits(mem_island_types_pkg::bank_idx_t)];
    assign dec_o.narrow_row   = narrow_addr_i[mem_island_cfg_pkg::ROW_LSB +:
                                              mem_island_cfg_pkg::ROW_W];
    assign dec_o.narrow_wdata = narrow_wdata_i;
    assign dec_o.narrow_be    = narrow_be_i;

    // Wide side
    // Top bit of the narrow bank select picks the pair
    assign dec_o.wide_valid = wide_req_i;
    assign dec_o.wide_we    = wide_we_i;
    assign dec_o.wide_pair  = wide_addr_i[mem_island_cfg_pkg::ROW_LSB-1];
    assign dec_o.wide_row   = wide_addr_i[mem_island_cfg_pkg::ROW_LSB +: mem_island_cfg_pkg::ROW_W];
    assign dec_o.wide_wdata = wide_wdata_i;
    assign dec_o.wide_be    = wide_be_i;

    // Address bits above the row field are outside the island
    a_narrow_addr_range : assert final (!narrow_req_i ||
        narrow_addr_i[mem_island_cfg_pkg::ADDR_W-1:mem_island_cfg_pkg::ROW_LSB+
                      mem_island_cfg_pkg::ROW_W] == '0)
        else $error("narrow request outside island address range");

    // Wide requests must also be 8-byte aligned
    a_wide_addr_range : assert final (!wide_req_i ||
        (wide_addr_i[mem_island_cfg_pkg::ADDR_W-1:mem_island_cfg_pkg::ROW_LSB+
                     mem_island_cfg_pkg::ROW_W] == '0 &&
         !wide_addr_i[mem_island_cfg_pkg::ROW_LSB-2]))
        else $error("wide request out of range or misaligned");

endmodule

// File: mem_island_ifs.sv
// Decoded request, per-bank request and response tag interfaces
`timescale 1ns/1ns

// ----------------------------------------------------------------------------
// Decoded requests of both ports
// ----------------------------------------------------------------------------
interface dec_req_if;
    // Narrow side
    logic                            narrow_valid;
    logic                            narrow_we;
    mem_island_types_pkg::bank_idx_t narrow_bank;
    mem_island_types_pkg::row_t      narrow_row;
    mem_island_types_pkg::ndata_t    narrow_wdata;
    mem_island_types_pkg::nbe_t      narrow_be;
    // Wide side
    logic                            wide_valid;
    logic                            wide_we;
    mem_island_types_pkg::pair_idx_t wide_pair;
    mem_island_types_pkg::row_t      wide_row;
    mem_island_types_pkg::wdata_t    wide_wdata;
    mem_island_types_pkg::wbe_t      wide_be;

    modport src (output narrow_valid, narrow_we, narrow_bank, narrow_row, narrow_wdata,
                        narrow_be, wide_valid, wide_we, wide_pair, wide_row, wide_wdata,
                        wide_be);
    modport dst (input  narrow_valid, narrow_we, narrow_bank, narrow_row, narrow_wdata,
                        narrow_be, wide_valid, wide_we, wide_pair, wide_row, wide_wdata,
                        wide_be);
endinterface

// ----------------------------------------------------------------------------
// Per-bank lanes after arbitration
// ----------------------------------------------------------------------------
interface bank_req_if;
    logic [mem_island_cfg_pkg::NUM_BANKS-1:0]                               en;
    logic [mem_island_cfg_pkg::NUM_BANKS-1:0]                               we;
    mem_island_types_pkg::row_t   [mem_island_cfg_pkg::NUM_BANKS-1:0] row;
    mem_island_types_pkg::ndata_t [mem_island_cfg_pkg::NUM_BANKS-1:0] wdata;
    mem_island_types_pkg::nbe_t   [mem_island_cfg_pkg::NUM_BANKS-1:0] be;

    modport arb (output en, we, row, wdata, be);
    modport mem (input  en, we, row, wdata, be);
endinterface

// ----------------------------------------------------------------------------
// Access tags of the cycle, used to route read data back
// ----------------------------------------------------------------------------
interface rsp_tag_if;
    logic                            narrow_acc;
    mem_island_types_pkg::bank_idx_t narrow_bank;
    logic                            wide_acc;
    mem_island_types_pkg::pair_idx_t wide_pair;

    modport arb   (output narrow_acc, narrow_bank, wide_acc, wide_pair);
    modport merge (input  narrow_acc, narrow_bank, wide_acc, wide_pair);
endinterface

// File: mem_island_types_pkg.sv
// Address, data, strobe and bank index types plus the conflict priority state
package mem_island_types_pkg;

    // Port byte address
    typedef logic [mem_island_cfg_pkg::ADDR_W-1:0] addr_t;

    // Word index inside one bank
    typedef logic [mem_island_cfg_pkg::ROW_W-1:0] row_t;

    // Narrow bank select and wide pair select
    typedef logic [$clog2(mem_island_cfg_pkg::NUM_BANKS)-1:0] bank_idx_t;
    typedef logic [$clog2(mem_island_cfg_pkg::NUM_PAIRS)-1:0] pair_idx_t;

    // Data words
    typedef logic [mem_island_cfg_pkg::NARROW_DW-1:0] ndata_t;
    typedef logic [mem_island_cfg_pkg::WIDE_DW-1:0]   wdata_t;

    // Byte strobes, one bit per data byte
    typedef logic [mem_island_cfg_pkg::NARROW_DW/8-1:0] nbe_t;
    typedef logic [mem_island_cfg_pkg::WIDE_DW/8-1:0]   wbe_t;

    // Conflict arbiter state
    // Names the port that wins the next bank conflict
    typedef enum logic {
        PRIO_NARROW,
        PRIO_WIDE
    } prio_e;

endpackage

// File: mem_island_cfg_pkg.sv
// Geometry and address field constants of the two-port memory island
package mem_island_cfg_pkg;

    // ------------------------------------------------------------------------
    // Bank geometry
    // ------------------------------------------------------------------------
    localparam int unsigned NUM_BANKS      = 4;
    localparam int unsigned WORDS_PER_BANK = 64;
    // Data widths of the two ports
    localparam int unsigned NARROW_DW      = 32;
    localparam int unsigned WIDE_DW        = 64;
    // One wide word spans an aligned pair of narrow banks
    localparam int unsigned BANKS_PER_WIDE = WIDE_DW / NARROW_DW;
    localparam int unsigned NUM_PAIRS      = NUM_BANKS / BANKS_PER_WIDE;

    // ------------------------------------------------------------------------
    // Address layout
    // ------------------------------------------------------------------------
    // Byte address, top bits must stay zero
    localparam int unsigned ADDR_W  = 12;
    // In-bank word index sits above bank select
    localparam int unsigned ROW_W   = 6;
    localparam int unsigned ROW_LSB = 4;
    // Acceptance edge to rvalid, in cycles
    localparam int unsigned RSP_LAT = 2;

endpackage
